/* source/tile_gfx_pkg.sv */
// ********************************************************************
// Shared types and constants of the scanline tile renderer.
// Width typedefs, tile map entry layout, render FSM states and a
// helper for index widths.
// ********************************************************************
package tile_gfx_pkg;

  // World is 512 by 512 pixels.
  localparam int WORLD_BITS = 9;
  typedef logic [WORLD_BITS-1:0] world_coord_t;

  // Tiles are 16 by 16 pixels.
  localparam int TILE_SIZE_LOG2 = 4;

  // Tile map word layout.
  typedef logic [15:0] map_entry_t;
  localparam int TILE_INDEX_WIDTH = 9;
  localparam int FLIP_XY_BIT = 13;
  localparam int FLIP_X_BIT = 14;
  localparam int FLIP_Y_BIT = 15;

  // Two 8-bit pixels per VRAM word, even pixel in the low byte.
  localparam int VRAM_ADDR_WIDTH = 16;
  typedef logic [15:0] vram_word_t;

  // Palette index within a bank, and the bank itself.
  typedef logic [7:0] pixel_t;
  typedef logic [1:0] pal_bank_t;
  localparam int PAL_ADDR_WIDTH = 10;

  // Palette color: red low byte, green middle byte, blue high byte.
  typedef logic [23:0] rgb24_t;
  localparam int RGB_OUT_WIDTH = 18;

  // Render FSM states.
  typedef enum logic [1:0] {
    idle,
    next_layer,
    draw_layer
  } render_state_t;

  // Bits needed to index count items, at least one.
  function automatic int index_width(input int count);
    return (count > 1) ? $clog2(count) : 1;
  endfunction

endpackage

/* source/layer_sequencer.sv */
`timescale 1ns/10ps
// ********************************************************************
// Layer sequencer of the tile renderer.
// FSM that walks the enabled layers and pixel positions of a line
// and flags the end of the line once the pipeline has drained.
// ********************************************************************
module layer_sequencer
  import tile_gfx_pkg::*;
#(
  parameter int NUM_LAYERS = 4,
  parameter int IMAGE_WIDTH = 320,
  parameter int LINE_ADDR_WIDTH = 9,
  localparam int LAYER_BITS = index_width(NUM_LAYERS)
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       line_start,
  input  logic [NUM_LAYERS-1:0]      layer_enable,
  output logic                       draw,
  output logic [LAYER_BITS-1:0]      layer,
  output logic [LINE_ADDR_WIDTH-1:0] render_x,
  output logic                       line_done
);

  localparam logic [LINE_ADDR_WIDTH-1:0] LAST_X = LINE_ADDR_WIDTH'(IMAGE_WIDTH - 1);
  localparam logic [LAYER_BITS-1:0] LAST_LAYER = LAYER_BITS'(NUM_LAYERS - 1);

  render_state_t state;
  logic last_layer;
  logic to_idle;
  logic finishing;
  // Draw flag history, one entry per pipeline stage still in flight.
  logic [1:0] draw_q;

  assign draw = (state == draw_layer);
  assign last_layer = (layer == LAST_LAYER);

  // Leaving the line, either from a skipped last layer or the last pixel.
  assign to_idle = last_layer &&
                   ((state == next_layer && !layer_enable[layer]) ||
                    (state == draw_layer && render_x == LAST_X));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= idle;
      layer <= '0;
      render_x <= '0;
    end else begin
      case (state)
        idle: begin
          // New line always starts at the lowest layer.
          if (line_start) begin
            state <= next_layer;
            layer <= '0;
          end
        end
        next_layer: begin
          render_x <= '0;
          if (layer_enable[layer]) begin
            state <= draw_layer;
          end else if (last_layer) begin
            state <= idle;
          end else begin
            // Disabled layer costs this one cycle.
            layer <= layer + 1'b1;
          end
        end
        draw_layer: begin
          if (render_x == LAST_X) begin
            if (to_idle) begin
              state <= idle;
            end else begin
              state <= next_layer;
              layer <= layer + 1'b1;
            end
          end else begin
            render_x <= render_x + 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Hold the end of line until the last pixels have left the pipeline.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      draw_q <= '0;
      finishing <= 1'b0;
    end else begin
      draw_q <= {draw_q[0], draw};
      if (to_idle) begin
        finishing <= 1'b1;
      end else if (line_done) begin
        finishing <= 1'b0;
      end
    end
  end

  // Coincides with the buffer write of the last drawn pixel.
  assign line_done = finishing && (draw_q == 2'b00);

endmodule

/* source/tile_address_gen.sv */
`timescale 1ns/10ps
// ********************************************************************
// Tile address generator.
// Scrolled render position to tile map address, then map entry and
// flip bits to VRAM word address and byte select.
// ********************************************************************
module tile_address_gen
  import tile_gfx_pkg::*;
#(
  parameter int NUM_LAYERS = 4,
  parameter int LINE_ADDR_WIDTH = 9,
  localparam int LAYER_BITS = index_width(NUM_LAYERS),
  localparam int MAP_ADDR_WIDTH = LAYER_BITS + 10
) (
  input  logic                       clk,
  input  logic                       draw,
  input  logic [LAYER_BITS-1:0]      layer,
  input  logic [LINE_ADDR_WIDTH-1:0] render_x,
  input  world_coord_t               line_y,
  input  world_coord_t               scroll_x,
  input  world_coord_t               scroll_y,
  input  logic [NUM_LAYERS-1:0]      layer_flip_enable,
  input  map_entry_t                 map_data,
  output logic [MAP_ADDR_WIDTH-1:0]  map_addr,
  output logic [VRAM_ADDR_WIDTH-1:0] vram_addr,
  output logic                       byte_sel,
  output logic [LAYER_BITS-1:0]      layer_q,
  output logic                       pixel_live
);

  world_coord_t world_x;
  world_coord_t world_y;
  logic [TILE_SIZE_LOG2-1:0] col_q;
  logic [TILE_SIZE_LOG2-1:0] row_q;
  logic [LAYER_BITS-1:0] layer_d1;
  logic draw_d1;
  logic flip_en;
  logic flip_x;
  logic flip_y;
  logic flip_xy;
  logic [TILE_SIZE_LOG2-1:0] swap_col;
  logic [TILE_SIZE_LOG2-1:0] swap_row;
  logic [TILE_SIZE_LOG2-1:0] tex_col;
  logic [TILE_SIZE_LOG2-1:0] tex_row;

  // Scrolled world position, wraps at 512.
  assign world_x = world_coord_t'(render_x) + scroll_x;
  assign world_y = line_y + scroll_y;

  // Map cell: layer, then 32 rows of 32 cells.
  assign map_addr = {layer,
                     world_y[WORLD_BITS-1:TILE_SIZE_LOG2],
                     world_x[WORLD_BITS-1:TILE_SIZE_LOG2]};

  // In-tile position waits for the map read.
  always_ff @(posedge clk) begin
    col_q <= world_x[TILE_SIZE_LOG2-1:0];
    row_q <= world_y[TILE_SIZE_LOG2-1:0];
    layer_d1 <= layer;
    draw_d1 <= draw;
  end

  // Flip bits only count when the layer enables them.
  assign flip_en = layer_flip_enable[layer_d1];
  assign flip_xy = flip_en & map_data[FLIP_XY_BIT];
  assign flip_x = flip_en & map_data[FLIP_X_BIT];
  assign flip_y = flip_en & map_data[FLIP_Y_BIT];

  always_comb begin
    // Diagonal flip transposes first.
    swap_col = flip_xy ? row_q : col_q;
    swap_row = flip_xy ? col_q : row_q;
    // Then mirror each axis.
    tex_col = flip_x ? ~swap_col : swap_col;
    tex_row = flip_y ? ~swap_row : swap_row;
  end

  // 128 words per tile, 8 words per tile row.
  assign vram_addr = {map_data[TILE_INDEX_WIDTH-1:0],
                      tex_row,
                      tex_col[TILE_SIZE_LOG2-1:1]};

  // Side data lines up with vram_data.
  always_ff @(posedge clk) begin
    byte_sel <= tex_col[0];
    layer_q <= layer_d1;
    pixel_live <= draw_d1;
  end

endmodule

/* source/texel_pipeline.sv */
`timescale 1ns/10ps
// ********************************************************************
// Texel pipeline.
// VRAM byte to palette address, color key test and line buffer
// write of the palette color.
// ********************************************************************
module texel_pipeline
  import tile_gfx_pkg::*;
#(
  parameter int NUM_LAYERS = 4,
  parameter int LINE_ADDR_WIDTH = 9,
  localparam int LAYER_BITS = index_width(NUM_LAYERS)
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 pixel_live,
  input  logic                                 byte_sel,
  input  logic [LAYER_BITS-1:0]                layer_q,
  input  logic [LINE_ADDR_WIDTH-1:0]           render_x,
  input  vram_word_t                           vram_data,
  input  logic [NUM_LAYERS-1:0]                layer_transp_enable,
  input  pixel_t [NUM_LAYERS-1:0]              layer_color_key,
  input  pal_bank_t [NUM_LAYERS-1:0]           layer_pal_bank,
  input  rgb24_t                               pal_data,
  output logic [PAL_ADDR_WIDTH-1:0]            pal_addr,
  output logic                                 buf_wr,
  output logic [LINE_ADDR_WIDTH-1:0]           buf_x,
  output rgb24_t                               buf_color
);

  pixel_t pixel;
  logic keyed;
  // Render x through the map, VRAM and palette stages.
  logic [2:0][LINE_ADDR_WIDTH-1:0] x_pipe;

  // Even pixel sits in the low byte.
  assign pixel = byte_sel ? vram_data[15:8] : vram_data[7:0];

  // Bank selects one of four 256 entry palettes.
  assign pal_addr = {layer_pal_bank[layer_q], pixel};

  // Key match hides the pixel.
  assign keyed = layer_transp_enable[layer_q] &&
                 (pixel == layer_color_key[layer_q]);

  always_ff @(posedge clk) begin
    x_pipe <= {x_pipe[1:0], render_x};
  end

  // Write decision waits one cycle for pal_data.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      buf_wr <= 1'b0;
    end else begin
      buf_wr <= pixel_live && !keyed;
    end
  end

  assign buf_x = x_pipe[2];

  // Palette color goes straight into the buffer.
  assign buf_color = pal_data;

endmodule

/* source/line_buffer.sv */
`timescale 1ns/10ps
// ********************************************************************
// Double line buffer.
// One half is rendered while the other is scanned out and cleared.
// ********************************************************************
module line_buffer
  import tile_gfx_pkg::*;
#(
  parameter int LINE_ADDR_WIDTH = 9
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       line_start,
  input  logic                       wr,
  input  logic [LINE_ADDR_WIDTH-1:0] wr_x,
  input  rgb24_t                     wr_color,
  input  logic                       rd,
  input  logic [LINE_ADDR_WIDTH-1:0] rd_x,
  output rgb24_t                     rd_color
);

  localparam int DEPTH = 2 << LINE_ADDR_WIDTH;

  rgb24_t mem [DEPTH];
  logic render_half;
  logic scan_half;

  // Halves swap on every new line.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      render_half <= 1'b0;
    end else if (line_start) begin
      render_half <= ~render_half;
    end
  end

  // Scanout takes the other half, already swapped when a line starts
  // in the same cycle.
  assign scan_half = ~(render_half ^ line_start);

  // Render port writes, scanout port reads and clears.
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[{render_half, wr_x}] <= wr_color;
    end
    if (rd) begin
      rd_color <= mem[{scan_half, rd_x}];
      mem[{scan_half, rd_x}] <= '0;
    end
  end

endmodule

/* source/line_scanout.sv */
`timescale 1ns/10ps
// ********************************************************************
// Line scanout.
// Reads one line from the buffer and drives 18-bit RGB.
// ********************************************************************
module line_scanout
  import tile_gfx_pkg::*;
#(
  parameter int IMAGE_WIDTH = 320,
  parameter int LINE_ADDR_WIDTH = 9
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       scan_start,
  input  rgb24_t                     rd_color,
  output logic                       rd,
  output logic [LINE_ADDR_WIDTH-1:0] rd_x,
  output logic [RGB_OUT_WIDTH-1:0]   rgb_out,
  output logic                       pixel_valid
);

  localparam logic [LINE_ADDR_WIDTH-1:0] LAST_X = LINE_ADDR_WIDTH'(IMAGE_WIDTH - 1);

  logic active;
  logic [LINE_ADDR_WIDTH-1:0] scan_x;
  logic rd_q;

  // First read goes out with the strobe itself.
  assign rd = scan_start | active;
  assign rd_x = scan_start ? '0 : scan_x;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      active <= 1'b0;
      scan_x <= '0;
      rd_q <= 1'b0;
      pixel_valid <= 1'b0;
    end else begin
      rd_q <= rd;
      pixel_valid <= rd_q;
      if (scan_start) begin
        // Strobe restarts a running scan.
        scan_x <= LINE_ADDR_WIDTH'(1);
        active <= (IMAGE_WIDTH > 1);
      end else if (active) begin
        if (scan_x == LAST_X) begin
          active <= 1'b0;
        end
        scan_x <= scan_x + 1'b1;
      end
    end
  end

  // Six top bits per channel, blue high, red low.
  always_ff @(posedge clk) begin
    if (rd_q) begin
      rgb_out <= {rd_color[23:18], rd_color[15:10], rd_color[7:2]};
    end
  end

endmodule

/* source/tile_renderer.sv */
`timescale 1ns/10ps
// ********************************************************************
// Scanline tile renderer, top level.
// Layer sequencer, address generator, texel pipeline, line buffer
// and scanout.
// ********************************************************************
module tile_renderer
  import tile_gfx_pkg::*;
#(
  parameter int NUM_LAYERS = 4,
  parameter int IMAGE_WIDTH = 320,
  parameter int LINE_ADDR_WIDTH = 9,
  localparam int LAYER_BITS = index_width(NUM_LAYERS),
  localparam int MAP_ADDR_WIDTH = LAYER_BITS + 10
) (
  input  logic                        clk,
  input  logic                        reset,
  // External memories, one cycle read latency.
  output logic [MAP_ADDR_WIDTH-1:0]   map_addr,
  input  map_entry_t                  map_data,
  output logic [VRAM_ADDR_WIDTH-1:0]  vram_addr,
  input  vram_word_t                  vram_data,
  output logic [PAL_ADDR_WIDTH-1:0]   pal_addr,
  input  rgb24_t                      pal_data,
  // Strobes.
  input  logic                        line_start,
  input  world_coord_t                line_y,
  output logic                        line_done,
  input  logic                        scan_start,
  // Registers, stable during a line.
  input  logic [NUM_LAYERS-1:0]       layer_enable,
  input  logic [NUM_LAYERS-1:0]       layer_transp_enable,
  input  logic [NUM_LAYERS-1:0]       layer_flip_enable,
  input  pixel_t [NUM_LAYERS-1:0]     layer_color_key,
  input  pal_bank_t [NUM_LAYERS-1:0]  layer_pal_bank,
  input  world_coord_t                scroll_x,
  input  world_coord_t                scroll_y,
  // Video out.
  output logic [RGB_OUT_WIDTH-1:0]    rgb_out,
  output logic                        pixel_valid
);

  logic draw;
  logic [LAYER_BITS-1:0] layer;
  logic [LINE_ADDR_WIDTH-1:0] render_x;
  logic byte_sel;
  logic [LAYER_BITS-1:0] layer_q;
  logic pixel_live;
  logic buf_wr;
  logic [LINE_ADDR_WIDTH-1:0] buf_x;
  rgb24_t buf_color;
  logic scan_rd;
  logic [LINE_ADDR_WIDTH-1:0] scan_x;
  rgb24_t scan_color;

  layer_sequencer #(
    .NUM_LAYERS     (NUM_LAYERS),
    .IMAGE_WIDTH    (IMAGE_WIDTH),
    .LINE_ADDR_WIDTH(LINE_ADDR_WIDTH)
  ) sequencer_i (
    .clk         (clk),
    .reset       (reset),
    .line_start  (line_start),
    .layer_enable(layer_enable),
    .draw        (draw),
    .layer       (layer),
    .render_x    (render_x),
    .line_done   (line_done)
  );

  tile_address_gen #(
    .NUM_LAYERS     (NUM_LAYERS),
    .LINE_ADDR_WIDTH(LINE_ADDR_WIDTH)
  ) address_gen_i (
    .clk              (clk),
    .draw             (draw),
    .layer            (layer),
    .render_x         (render_x),
    .line_y           (line_y),
    .scroll_x         (scroll_x),
    .scroll_y         (scroll_y),
    .layer_flip_enable(layer_flip_enable),
    .map_data         (map_data),
    .map_addr         (map_addr),
    .vram_addr        (vram_addr),
    .byte_sel         (byte_sel),
    .layer_q          (layer_q),
    .pixel_live       (pixel_live)
  );

  texel_pipeline #(
    .NUM_LAYERS     (NUM_LAYERS),
    .LINE_ADDR_WIDTH(LINE_ADDR_WIDTH)
  ) texel_i (
    .clk                (clk),
    .reset              (reset),
    .pixel_live         (pixel_live),
    .byte_sel           (byte_sel),
    .layer_q            (layer_q),
    .render_x           (render_x),
    .vram_data          (vram_data),
    .layer_transp_enable(layer_transp_enable),
    .layer_color_key    (layer_color_key),
    .layer_pal_bank     (layer_pal_bank),
    .pal_data           (pal_data),
    .pal_addr           (pal_addr),
    .buf_wr             (buf_wr),
    .buf_x              (buf_x),
    .buf_color          (buf_color)
  );

  line_buffer #(
    .LINE_ADDR_WIDTH(LINE_ADDR_WIDTH)
  ) line_buffer_i (
    .clk       (clk),
    .reset     (reset),
    .line_start(line_start),
    .wr        (buf_wr),
    .wr_x      (buf_x),
    .wr_color  (buf_color),
    .rd        (scan_rd),
    .rd_x      (scan_x),
    .rd_color  (scan_color)
  );

  line_scanout #(
    .IMAGE_WIDTH    (IMAGE_WIDTH),
    .LINE_ADDR_WIDTH(LINE_ADDR_WIDTH)
  ) scanout_i (
    .clk        (clk),
    .reset      (reset),
    .scan_start (scan_start),
    .rd_color   (scan_color),
    .rd         (scan_rd),
    .rd_x       (scan_x),
    .rgb_out    (rgb_out),
    .pixel_valid(pixel_valid)
  );

endmodule

/* testbench/tile_renderer_model.svh */
// **********************************************************************
// Reference model of the tile renderer.
// Random fill of the tile map, VRAM and palette, and the expected
// 18-bit scanout line for one test.
// **********************************************************************
`ifndef TILE_RENDERER_MODEL_SVH
`define TILE_RENDERER_MODEL_SVH

  // Memory contents, shared with the memory models.
  map_entry_t map_mem [1 << MAP_ADDR_WIDTH];
  vram_word_t vram_mem [1 << VRAM_ADDR_WIDTH];
  rgb24_t pal_mem [1 << PAL_ADDR_WIDTH];

  // Expected scanout of the line under test.
  logic [RGB_OUT_WIDTH-1:0] expected_line [$];

  int seed;

  function automatic pixel_t random_pixel();
    logic [31:0] rnd;
    rnd = $random(seed);
    // About half the pixels fall in 0 to 3 so that color keys hit often.
    return rnd[8] ? pixel_t'(rnd[1:0]) : rnd[7:0];
  endfunction

  task automatic fill_memories();
    seed = 35;
    for (int i = 0; i < (1 << MAP_ADDR_WIDTH); i++) begin
      map_mem[MAP_ADDR_WIDTH'(i)] = map_entry_t'($random(seed));
    end
    for (int i = 0; i < (1 << VRAM_ADDR_WIDTH); i++) begin
      vram_mem[VRAM_ADDR_WIDTH'(i)] = {random_pixel(), random_pixel()};
    end
    for (int i = 0; i < (1 << PAL_ADDR_WIDTH); i++) begin
      pal_mem[PAL_ADDR_WIDTH'(i)] = rgb24_t'($random(seed));
    end
    // First eight cells of each layer carry every flip combination.
    for (int l = 0; l < NUM_LAYERS; l++) begin
      for (int c = 0; c < 8; c++) begin
        map_mem[MAP_ADDR_WIDTH'(l * 1024 + c)][FLIP_Y_BIT -: 3] = 3'(c);
      end
    end
  endtask

  function automatic logic [RGB_OUT_WIDTH-1:0] to_rgb18(input rgb24_t color);
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    red = color[7:0];
    green = color[15:8];
    blue = color[23:16];
    // Six most significant bits per channel, blue on top.
    return {blue[7:2], green[7:2], red[7:2]};
  endfunction

  task automatic compute_expected_line(input line_test_t t);
    int wx;
    int wy;
    int col;
    int row;
    int swap;
    logic [LAYER_BITS-1:0] lidx;
    map_entry_t entry;
    vram_word_t word;
    pixel_t pix;
    rgb24_t color;
    expected_line.delete();
    for (int x = 0; x < IMAGE_WIDTH; x++) begin
      // Black until some layer draws here.
      color = '0;
      for (int l = 0; l < NUM_LAYERS; l++) begin
        lidx = LAYER_BITS'(l);
        if (t.enable[lidx]) begin
          wx = (x + int'(t.scroll_x)) % 512;
          wy = (int'(t.line_y) + int'(t.scroll_y)) % 512;
          // 32 by 32 cells per layer.
          entry = map_mem[MAP_ADDR_WIDTH'(l * 1024 + (wy / 16) * 32 + wx / 16)];
          col = wx % 16;
          row = wy % 16;
          if (t.flip[lidx]) begin
            // Transpose first, then mirror.
            if (entry[FLIP_XY_BIT]) begin
              swap = col;
              col = row;
              row = swap;
            end
            if (entry[FLIP_X_BIT]) begin
              col = 15 - col;
            end
            if (entry[FLIP_Y_BIT]) begin
              row = 15 - row;
            end
          end
          word = vram_mem[VRAM_ADDR_WIDTH'(int'(entry[TILE_INDEX_WIDTH-1:0]) * 128 +
                                          row * 8 + col / 2)];
          pix = (col % 2 == 1) ? word[15:8] : word[7:0];
          // Keyed pixel leaves the layers below visible.
          if (!(t.transp[lidx] && pix == t.keys[lidx])) begin
            color = pal_mem[PAL_ADDR_WIDTH'(int'(t.banks[lidx]) * 256 + int'(pix))];
          end
        end
      end
      expected_line.push_back(to_rgb18(color));
    end
  endtask

`endif

/* testbench/tile_renderer_tb.sv */
`timescale 1ns/10ps
// **********************************************************************
// Testbench of the scanline tile renderer.
// Clock and reset, tile map, VRAM and palette models, a table of line
// tests applied in a loop with scanout checks, and a watchdog.
// **********************************************************************
module tile_renderer_tb
  import tile_gfx_pkg::*;
();

  // DUT runs with its default parameters.
  localparam int NUM_LAYERS = 4;
  localparam int IMAGE_WIDTH = 320;
  localparam int LAYER_BITS = 2;
  localparam int MAP_ADDR_WIDTH = LAYER_BITS + 10;
  localparam int CLK_PERIOD = 10;
  localparam int DRIVE_DELAY = 1;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_TESTS = 8;
  localparam int TEST_BITS = 3;
  // Each test renders one line and scans it out.
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 6 * IMAGE_WIDTH;

  // One line test holds the position, scroll and layer registers.
  typedef struct packed {
    world_coord_t line_y;
    world_coord_t scroll_x;
    world_coord_t scroll_y;
    logic [NUM_LAYERS-1:0] enable;
    logic [NUM_LAYERS-1:0] transp;
    logic [NUM_LAYERS-1:0] flip;
    pixel_t [NUM_LAYERS-1:0] keys;
    pal_bank_t [NUM_LAYERS-1:0] banks;
  } line_test_t;

  logic clk = 1'b0;
  logic reset;
  logic [MAP_ADDR_WIDTH-1:0] map_addr;
  map_entry_t map_data = '0;
  logic [VRAM_ADDR_WIDTH-1:0] vram_addr;
  vram_word_t vram_data = '0;
  logic [PAL_ADDR_WIDTH-1:0] pal_addr;
  rgb24_t pal_data = '0;
  logic line_start;
  world_coord_t line_y;
  logic line_done;
  logic scan_start;
  logic [NUM_LAYERS-1:0] layer_enable;
  logic [NUM_LAYERS-1:0] layer_transp_enable;
  logic [NUM_LAYERS-1:0] layer_flip_enable;
  pixel_t [NUM_LAYERS-1:0] layer_color_key;
  pal_bank_t [NUM_LAYERS-1:0] layer_pal_bank;
  world_coord_t scroll_x;
  world_coord_t scroll_y;
  logic [RGB_OUT_WIDTH-1:0] rgb_out;
  logic pixel_valid;

  line_test_t tests [NUM_TESTS];
  int lines_done = 0;

  `include "tile_renderer_model.svh"

  tile_renderer dut_i (
    .clk                (clk),
    .reset              (reset),
    .map_addr           (map_addr),
    .map_data           (map_data),
    .vram_addr          (vram_addr),
    .vram_data          (vram_data),
    .pal_addr           (pal_addr),
    .pal_data           (pal_data),
    .line_start         (line_start),
    .line_y             (line_y),
    .line_done          (line_done),
    .scan_start         (scan_start),
    .layer_enable       (layer_enable),
    .layer_transp_enable(layer_transp_enable),
    .layer_flip_enable  (layer_flip_enable),
    .layer_color_key    (layer_color_key),
    .layer_pal_bank     (layer_pal_bank),
    .scroll_x           (scroll_x),
    .scroll_y           (scroll_y),
    .rgb_out            (rgb_out),
    .pixel_valid        (pixel_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Synchronous memories return data one clock after the address.
  always @(posedge clk) begin
    map_data <= map_mem[map_addr];
    vram_data <= vram_mem[vram_addr];
    pal_data <= pal_mem[pal_addr];
  end

  // Count line_done strobes away from the rising edge.
  always @(negedge clk) begin
    if (line_done) begin
      lines_done <= lines_done + 1;
    end
  end

  // Line y, scroll x, scroll y, enable, transparency, flip, keys, banks.
  task automatic load_tests();
    // Single plain layer.
    tests[0] = '{9'd5, 9'd0, 9'd0, 4'b0001, 4'b0000, 4'b0000, 32'h0, 8'h02};
    // Scroll near the world edge wraps both axes.
    tests[1] = '{9'd200, 9'd500, 9'd490, 4'b0010, 4'b0000, 4'b0000, 32'h0, 8'h0c};
    // Map row 0 holds every flip combination. Flip enabled, then disabled.
    tests[2] = '{9'd7, 9'd0, 9'd0, 4'b0001, 4'b0000, 4'b0001, 32'h0, 8'h01};
    tests[3] = '{9'd7, 9'd0, 9'd0, 4'b0001, 4'b0000, 4'b0000, 32'h0, 8'h01};
    // All layers keyed on small pixel values.
    tests[4] = '{9'd100, 9'd37, 9'd3, 4'b1111, 4'b1111, 4'b0101, 32'h03020100, 8'he4};
    // Two layers on the same key leave black where both are keyed.
    tests[5] = '{9'd301, 9'd11, 9'd500, 4'b0011, 4'b0011, 4'b0011, 32'h0, 8'h06};
    // Nothing enabled.
    tests[6] = '{9'd50, 9'd3, 9'd9, 4'b0000, 4'b1111, 4'b1111, 32'h0, 8'hff};
    tests[7] = '{9'd511, 9'd1, 9'd1, 4'b1001, 4'b1000, 4'b1001, 32'h02000000, 8'h4b};
  endtask

  task automatic next_drive_slot();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic apply_registers(input line_test_t t);
    line_y = t.line_y;
    scroll_x = t.scroll_x;
    scroll_y = t.scroll_y;
    layer_enable = t.enable;
    layer_transp_enable = t.transp;
    layer_flip_enable = t.flip;
    layer_color_key = t.keys;
    layer_pal_bank = t.banks;
  endtask

  task automatic stop_on_failure(input string text);
    $display("%s", text);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first failed check.");
  endtask

  task automatic check_idle_outputs(input string phase);
    assert (!line_done && !pixel_valid)
    else stop_on_failure($sformatf("line_done or pixel_valid is high %s.", phase));
  endtask

  task automatic wait_lines_done(input int target);
    while (lines_done < target) begin
      @(negedge clk);
    end
  endtask

  // Valid pixels must come as one unbroken run of a full line.
  task automatic check_scanned_line(input int test_idx);
    logic [RGB_OUT_WIDTH-1:0] expected;
    while (!pixel_valid) begin
      @(negedge clk);
    end
    for (int x = 0; x < IMAGE_WIDTH; x++) begin
      expected = expected_line[x];
      assert (pixel_valid)
      else stop_on_failure($sformatf("pixel_valid dropped after %0d pixels in test %0d.",
                                     x, test_idx));
      assert (rgb_out == expected)
      else stop_on_failure($sformatf(
        "ERROR: time %0d ns, test %0d pixel %0d, got %05h, expected %05h",
        $time, test_idx, x, rgb_out, expected));
      @(negedge clk);
    end
    assert (!pixel_valid)
    else stop_on_failure($sformatf("pixel_valid stayed high past the line in test %0d.",
                                   test_idx));
  endtask

  initial begin
    line_test_t cur;
    int target;
    reset = 1'b1;
    line_start = 1'b0;
    scan_start = 1'b0;
    line_y = '0;
    scroll_x = '0;
    scroll_y = '0;
    layer_enable = '0;
    layer_transp_enable = '0;
    layer_flip_enable = '0;
    layer_color_key = '0;
    layer_pal_bank = '0;
    load_tests();
    fill_memories();
    // Release after the tenth rising edge.
    repeat (RESET_CYCLES - 1) begin
      @(negedge clk);
      check_idle_outputs("during reset");
    end
    next_drive_slot();
    reset = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_idle_outputs("right after reset");
    end
    for (int i = 0; i < NUM_TESTS; i++) begin
      cur = tests[TEST_BITS'(i)];
      compute_expected_line(cur);
      // Render the line under test.
      target = lines_done + 1;
      next_drive_slot();
      apply_registers(cur);
      line_start = 1'b1;
      next_drive_slot();
      line_start = 1'b0;
      wait_lines_done(target);
      // Blank line swaps the halves while the rendered one is scanned.
      target = lines_done + 1;
      next_drive_slot();
      layer_enable = '0;
      line_start = 1'b1;
      scan_start = 1'b1;
      next_drive_slot();
      line_start = 1'b0;
      scan_start = 1'b0;
      check_scanned_line(i);
      wait_lines_done(target);
    end
    $display("STATUS: PASS");
    $finish;
  end

  // Watchdog.
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout, the tests did not finish within %0d clock cycles.", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $fatal(1, "Watchdog expired.");
  end

endmodule

/* files.f */
+incdir+testbench
source/tile_gfx_pkg.sv
source/layer_sequencer.sv
source/tile_address_gen.sv
source/texel_pipeline.sv
source/line_buffer.sv
source/line_scanout.sv
source/tile_renderer.sv
testbench/tile_renderer_tb.sv

/* Makefile */
# Verilator build and run of the tile renderer testbench.

SIM = obj_dir/tile_renderer_sim

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): files.f source/*.sv testbench/*.sv testbench/*.svh
	verilator --binary --timing --assert -f files.f --top-module tile_renderer_tb -Mdir obj_dir -o tile_renderer_sim

run: $(SIM)
	-$(SIM) > sim.log 2>&1
	cat sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
